// File: dv/icache_checker.sv
`timescale 1ns/1ps

module icache_checker (
    input logic clk,
    input logic arst_n,
    input logic mem_req,
    input logic mem_addr_ok,
    input logic mem_data_ok,
    input logic ready,
    input logic stall,
    input logic hold
);

    int   assert_fails = 0;
    logic outstanding;

    // one memory transaction in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            outstanding <= 1'b1;
        end else if (mem_data_ok) begin
            outstanding <= 1'b0;
        end
    end

    reset_state: assert property (@(posedge clk) $rose(arst_n) |-> (ready && !mem_req))
        else begin
            assert_fails++;
            $error("ready low or mem_req high right after reset");
        end

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req && !mem_addr_ok) |=> mem_req)
        else begin
            assert_fails++;
            $error("mem_req dropped before mem_addr_ok");
        end

    ready_gated: assert property (@(posedge clk) disable iff (!arst_n)
        (stall || hold) |-> !ready)
        else begin
            assert_fails++;
            $error("ready high during stall or hold");
        end

    data_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        mem_data_ok |-> outstanding)
        else begin
            assert_fails++;
            $error("mem_data_ok without an accepted mem_req");
        end

endmodule

bind icache icache_checker u_checker (.*);

// File: dv/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         mem_req,
    input  logic [31:0]  mem_addr,
    output logic         mem_addr_ok,
    output logic         mem_data_ok,
    output logic [127:0] mem_line
);

    import icache_pkg::*;

    integer      seed;
    int          delay;
    logic [1:0]  phase;
    logic        req_seen;
    logic [31:0] addr_seen;
    logic [31:0] line_base;

    // every word holds its own byte address, scrambled
    function automatic logic [127:0] line_for(input logic [31:0] base);
        logic [127:0] line;
        for (int i = 0; i < line_words; i++) begin
            line[32*i +: 32] = (base + 32'(4 * i)) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    initial begin
        seed = 32'h2e01_c42e;
    end

    // request sampled between edges
    always @(negedge clk) begin
        req_seen  = mem_req;
        addr_seen = mem_addr;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase       <= 2'd0;
            delay       <= 0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_line    <= '0;
            line_base   <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            case (phase)
                2'd0: begin
                    if (req_seen) begin
                        delay <= $unsigned($random(seed)) % 4;
                        phase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (delay == 0) begin
                        mem_addr_ok <= 1'b1;
                        line_base   <= {addr_seen[31:4], 4'h0};
                        phase       <= 2'd2;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                2'd2: begin
                    mem_data_ok <= 1'b1;
                    mem_line    <= line_for(line_base);
                    phase       <= 2'd3;
                end
                default: phase <= 2'd0;
            endcase
        end
    end

endmodule

// File: dv/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    import icache_pkg::*;

    // 6 tests, worst miss about 12 cycles, up to 12 requests each, doubled
    localparam int timeout_cycles = 6 * 12 * 12 * 2;

    logic                   clk;
    logic                   arst_n;
    logic                   valid;
    logic                   ready;
    logic [31:0]            addr;
    logic                   uncached;
    logic                   cacop;
    logic [cacop_width-1:0] cacop_code;
    logic                   hold;
    logic [63:0]            inst;
    logic                   pair_ok;
    logic [31:0]            pc;
    logic                   stall;
    logic                   mem_req;
    logic [31:0]            mem_addr;
    logic                   mem_uncached;
    logic                   mem_addr_ok;
    logic                   mem_data_ok;
    logic [127:0]           mem_line;

    int          check_errors = 0;
    int          other_errors = 0;
    int          req_count = 0;
    int          cycles = 0;
    logic [31:0] last_req_addr;
    logic        last_req_unc;
    logic        stalled;

    tb_clk_gen u_clk (.clk(clk));

    icache DUT (.*);

    icache_mem_model u_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    // accepted memory requests, counted between edges
    always @(negedge clk) begin
        if (mem_req && mem_addr_ok) begin
            req_count++;
            last_req_addr = mem_addr;
            last_req_unc  = mem_uncached;
        end
    end

    //////////////////////////////////////////////////
    // expected values and compares
    //////////////////////////////////////////////////

    function automatic logic [63:0] expected_inst(input logic [31:0] a);
        icache_line_u line;
        logic [31:0]  base;
        base = {a[31:4], 4'h0};
        for (int i = 0; i < line_words; i++) begin
            line.word[i] = (base + 32'(4 * i)) ^ 32'hA5A5_0000;
        end
        // odd word alone in the low half
        case (a[3:2])
            2'd0:    return {line.word[1], line.word[0]};
            2'd1:    return {32'd0, line.word[1]};
            2'd2:    return {line.word[3], line.word[2]};
            default: return {32'd0, line.word[3]};
        endcase
    endfunction

    task automatic check_inst(input logic [63:0] exp_inst, input logic exp_pair_ok);
        logic [63:0] mask;
        mask = exp_pair_ok ? 64'hFFFF_FFFF_FFFF_FFFF : 64'h0000_0000_FFFF_FFFF;
        if (pair_ok !== exp_pair_ok) begin
            check_errors++;
            $display("CHECK FAILED t=%0t pair_ok exp=%b got=%b", $time, exp_pair_ok, pair_ok);
        end
        if ((inst & mask) !== (exp_inst & mask)) begin
            check_errors++;
            $display("CHECK FAILED t=%0t inst exp=%h got=%h", $time, exp_inst & mask,
                     inst & mask);
        end
    endtask

    task automatic check_pc(input logic [31:0] exp_pc);
        if (pc !== exp_pc) begin
            check_errors++;
            $display("CHECK FAILED t=%0t pc exp=%h got=%h", $time, exp_pc, pc);
        end
    endtask

    task automatic check_mem_req(input int start, input int exp_count,
                                 input logic [31:0] exp_addr);
        if (req_count - start != exp_count) begin
            check_errors++;
            $display("CHECK FAILED t=%0t mem_req count exp=%0d got=%0d", $time, exp_count,
                     req_count - start);
        end else if (exp_count > 0 && last_req_addr !== exp_addr) begin
            check_errors++;
            $display("CHECK FAILED t=%0t mem_addr exp=%h got=%h", $time, exp_addr,
                     last_req_addr);
        end
    endtask

    //////////////////////////////////////////////////
    // request driving
    //////////////////////////////////////////////////

    task automatic drive_request(input logic [31:0] a, input logic unc, input logic op,
                                 input logic [cacop_width-1:0] code);
        @(posedge clk);
        valid      <= 1'b1;
        addr       <= a;
        uncached   <= unc;
        cacop      <= op;
        cacop_code <= code;
    endtask

    // wait for acceptance, then for the response cycle
    task automatic complete_request();
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        valid   <= 1'b0;
        cacop   <= 1'b0;
        stalled = 1'b0;
        @(negedge clk);
        while (stall) begin
            stalled = 1'b1;
            @(negedge clk);
        end
    endtask

    task automatic fetch_check(input logic [31:0] a, input logic unc, input int exp_reqs);
        int start;
        start = req_count;
        drive_request(a, unc, 1'b0, cacop_set_init);
        complete_request();
        if (stalled != (exp_reqs > 0)) begin
            other_errors++;
            $display("stall at %0t did not match a %s", $time, stalled ? "hit" : "miss");
        end
        check_mem_req(start, exp_reqs, {a[31:4], 4'h0});
        check_inst(expected_inst(a), ~a[2]);
        check_pc(a);
    endtask

    task automatic cache_op(input logic [cacop_width-1:0] code, input logic [31:0] a);
        drive_request(a, 1'b0, 1'b1, code);
        complete_request();
        if (stalled) begin
            other_errors++;
            $display("cache operation at %0t raised stall", $time);
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic cold_miss_then_hit();
        fetch_check(32'h0000_0100, 1'b0, 1);
        fetch_check(32'h0000_0100, 1'b0, 0);
    endtask

    task automatic dual_issue_select();
        fetch_check(32'h0000_0230, 1'b0, 1);
        for (int o = 0; o < line_words; o++) begin
            fetch_check(32'h0000_0230 + 32'(4 * o), 1'b0, 0);
        end
    endtask

    // three tags at set 4, B is evicted by C
    task automatic lru_replace();
        fetch_check(32'h0000_1040, 1'b0, 1);
        fetch_check(32'h0000_2040, 1'b0, 1);
        fetch_check(32'h0000_1040, 1'b0, 0);
        fetch_check(32'h0000_3040, 1'b0, 1);
        fetch_check(32'h0000_1040, 1'b0, 0);
        fetch_check(32'h0000_2040, 1'b0, 1);
    endtask

    task automatic uncached_fetch();
        fetch_check(32'h0000_058C, 1'b1, 1);
        if (!last_req_unc) begin
            other_errors++;
            $display("uncached fetch at %0t left mem_uncached low", $time);
        end
        fetch_check(32'h0000_058C, 1'b1, 1);
        // nothing was allocated
        fetch_check(32'h0000_058C, 1'b0, 1);
    endtask

    // hold rises at the acceptance edge of the next fetch
    task automatic hold_output();
        int start;
        fetch_check(32'h0000_0108, 1'b0, 0);
        start = req_count;
        drive_request(32'h0000_0104, 1'b0, 1'b0, cacop_set_init);
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        valid <= 1'b0;
        hold  <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (ready) begin
                other_errors++;
                $display("ready high at %0t while hold is high", $time);
            end
            check_inst(expected_inst(32'h0000_0108), 1'b1);
            check_pc(32'h0000_0108);
        end
        @(posedge clk);
        hold <= 1'b0;
        @(negedge clk);
        if (stall) begin
            other_errors++;
            $display("stall high at %0t on a hit after hold fell", $time);
        end
        check_mem_req(start, 0, 32'h0000_0100);
        check_inst(expected_inst(32'h0000_0104), 1'b0);
        check_pc(32'h0000_0104);
        fetch_check(32'h0000_010C, 1'b0, 0);
    endtask

    // x in way 0 and y in way 1 of set 12
    task automatic cache_ops();
        fetch_check(32'h0000_40C0, 1'b0, 1);
        fetch_check(32'h0000_50C0, 1'b0, 1);
        cache_op(cacop_idx_inv, 32'h0000_40C0);
        fetch_check(32'h0000_40C0, 1'b0, 1);
        fetch_check(32'h0000_50C0, 1'b0, 0);
        cache_op(cacop_hit_inv, 32'h0000_50C0);
        fetch_check(32'h0000_40C0, 1'b0, 0);
        fetch_check(32'h0000_50C0, 1'b0, 1);
        cache_op(cacop_set_init, 32'h0000_40C0);
        fetch_check(32'h0000_40C0, 1'b0, 1);
        fetch_check(32'h0000_50C0, 1'b0, 1);
    endtask

    task automatic report_and_finish();
        int total;
        total = check_errors + other_errors + DUT.u_checker.assert_fails;
        $display("errors: checks=%0d assertions=%0d other=%0d", check_errors,
                 DUT.u_checker.assert_fails, other_errors);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        other_errors++;
        $display("timeout after %0d cycles", timeout_cycles);
        report_and_finish();
    end

    initial begin
        arst_n     = 1'b0;
        valid      = 1'b0;
        addr       = '0;
        uncached   = 1'b0;
        cacop      = 1'b0;
        cacop_code = '0;
        hold       = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        cold_miss_then_hit();
        dual_issue_select();
        lru_replace();
        uncached_fetch();
        hold_output();
        cache_ops();
        report_and_finish();
    end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

// File: src.f
verilog/icache_pkg.sv
verilog/icache_rbuf.sv
verilog/icache_lru.sv
verilog/icache_data.sv
verilog/icache_tagv.sv
verilog/icache_fsm.sv
verilog/icache.sv
dv/tb_clk_gen.sv
dv/icache_mem_model.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: verilog/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               valid,
    output logic                               ready,
    input  logic [31:0]                        addr,
    input  logic                               uncached,
    input  logic                               cacop,
    input  logic [icache_pkg::cacop_width-1:0] cacop_code,
    input  logic                               hold,
    output logic [63:0]                        inst,
    output logic                               pair_ok,
    output logic [31:0]                        pc,
    output logic                               stall,
    output logic                               mem_req,
    output logic [31:0]                        mem_addr,
    output logic                               mem_uncached,
    input  logic                               mem_addr_ok,
    input  logic                               mem_data_ok,
    input  logic [127:0]                       mem_line
);

    import icache_pkg::*;

    logic [31:0]             buf_addr;
    logic                    buf_uncached;
    logic                    buf_cacop;
    logic [cacop_width-1:0]  buf_cacop_code;
    logic [index_width-1:0]  fetch_index;
    logic [index_width-1:0]  buf_index;
    logic [index_width-1:0]  rd_index;
    logic [offset_width-1:0] buf_offset;
    logic [tag_width-1:0]    buf_tag;
    logic                    buf_we;
    logic                    lru_touch;
    logic                    lru_way;
    logic                    victim;
    logic [1:0]              hit;
    logic [1:0]              data_we;
    logic [1:0]              tag_we;
    logic [1:0]              tag_inv;
    logic                    tag_init;
    logic                    sel_return;
    logic                    sel_way;
    icache_line_u            rd_line0;
    icache_line_u            rd_line1;
    icache_line_u            ret_line;
    icache_line_u            cur_line;
    logic [63:0]             live_inst;
    logic                    live_pair_ok;
    logic [63:0]             inst_q;
    logic                    pair_ok_q;
    logic [31:0]             pc_q;

    //////////////////////////////////////////////////
    // address slicing
    //////////////////////////////////////////////////

    assign fetch_index = addr[offset_width+2 +: index_width];
    assign buf_index   = buf_addr[offset_width+2 +: index_width];
    assign buf_offset  = buf_addr[2 +: offset_width];
    assign buf_tag     = buf_addr[31 -: tag_width];

    // arrays re-read the buffered set unless a new fetch is taken
    assign rd_index = buf_we ? fetch_index : buf_index;

    assign mem_addr     = {buf_addr[31:offset_width+2], {(offset_width + 2){1'b0}}};
    assign mem_uncached = buf_uncached;

    icache_rbuf u_rbuf (
        .clk            (clk),
        .arst_n         (arst_n),
        .we             (buf_we),
        .hold           (hold),
        .addr           (addr),
        .uncached       (uncached),
        .cacop          (cacop),
        .cacop_code     (cacop_code),
        .buf_addr       (buf_addr),
        .buf_uncached   (buf_uncached),
        .buf_cacop      (buf_cacop),
        .buf_cacop_code (buf_cacop_code)
    );

    icache_lru u_lru (
        .clk     (clk),
        .arst_n  (arst_n),
        .index   (buf_index),
        .hit_way (lru_way),
        .touch   (lru_touch),
        .victim  (victim)
    );

    icache_data u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1),
        .wr_index (buf_index),
        .wr_line  (mem_line),
        .wr_en    (data_we)
    );

    icache_tagv u_tagv (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_index (rd_index),
        .cmp_tag  (buf_tag),
        .hit      (hit),
        .wr_index (buf_index),
        .wr_tag   (buf_tag),
        .wr_en    (tag_we),
        .inv_en   (tag_inv),
        .set_init (tag_init)
    );

    icache_fsm u_fsm (
        .clk            (clk),
        .arst_n         (arst_n),
        .valid          (valid),
        .hold           (hold),
        .ready          (ready),
        .stall          (stall),
        .buf_uncached   (buf_uncached),
        .buf_cacop      (buf_cacop),
        .buf_cacop_code (buf_cacop_code),
        .buf_way_bit    (buf_addr[0]),
        .hit            (hit),
        .victim         (victim),
        .buf_we         (buf_we),
        .lru_touch      (lru_touch),
        .lru_way        (lru_way),
        .data_we        (data_we),
        .tag_we         (tag_we),
        .tag_inv        (tag_inv),
        .tag_init       (tag_init),
        .mem_req        (mem_req),
        .mem_addr_ok    (mem_addr_ok),
        .mem_data_ok    (mem_data_ok),
        .sel_return     (sel_return),
        .sel_way        (sel_way)
    );

    //////////////////////////////////////////////////
    // line and word select
    //////////////////////////////////////////////////

    // returned line, shown in the cycle after data_ok
    always_ff @(posedge clk) begin
        if (mem_data_ok) begin
            ret_line <= mem_line;
        end
    end

    always_comb begin
        if (sel_return) begin
            cur_line = ret_line;
        end else if (sel_way) begin
            cur_line = rd_line1;
        end else begin
            cur_line = rd_line0;
        end
    end

    // odd offset gives one instruction, even gives a pair
    always_comb begin
        if (buf_offset[0]) begin
            live_inst    = {32'd0, cur_line.word[buf_offset]};
            live_pair_ok = 1'b0;
        end else begin
            live_inst    = cur_line.pair[buf_offset[1]];
            live_pair_ok = 1'b1;
        end
    end

    // last output, replayed while the pipeline holds
    always_ff @(posedge clk) begin
        inst_q    <= inst;
        pair_ok_q <= pair_ok;
        pc_q      <= pc;
    end

    assign inst    = hold ? inst_q : live_inst;
    assign pair_ok = hold ? pair_ok_q : live_pair_ok;
    assign pc      = hold ? pc_q : buf_addr;

endmodule

// File: verilog/icache_data.sv
`timescale 1ns/1ps

module icache_data (
    input  logic                               clk,
    input  logic [icache_pkg::index_width-1:0] rd_index,
    output icache_pkg::icache_line_u           rd_line0,
    output icache_pkg::icache_line_u           rd_line1,
    input  logic [icache_pkg::index_width-1:0] wr_index,
    input  icache_pkg::icache_line_u           wr_line,
    input  logic [1:0]                         wr_en
);

    import icache_pkg::*;

    icache_line_u way0_mem [set_count];
    icache_line_u way1_mem [set_count];

    // refill writes a whole line into one way
    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            way0_mem[wr_index] <= wr_line;
        end
        if (wr_en[1]) begin
            way1_mem[wr_index] <= wr_line;
        end
    end

    // synchronous read, lines line up with the buffered request
    always_ff @(posedge clk) begin
        rd_line0 <= way0_mem[rd_index];
        rd_line1 <= way1_mem[rd_index];
    end

endmodule

// File: verilog/icache_fsm.sv
`timescale 1ns/1ps

module icache_fsm (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               valid,
    input  logic                               hold,
    output logic                               ready,
    output logic                               stall,
    input  logic                               buf_uncached,
    input  logic                               buf_cacop,
    input  logic [icache_pkg::cacop_width-1:0] buf_cacop_code,
    input  logic                               buf_way_bit,
    input  logic [1:0]                         hit,
    input  logic                               victim,
    output logic                               buf_we,
    output logic                               lru_touch,
    output logic                               lru_way,
    output logic [1:0]                         data_we,
    output logic [1:0]                         tag_we,
    output logic [1:0]                         tag_inv,
    output logic                               tag_init,
    output logic                               mem_req,
    input  logic                               mem_addr_ok,
    input  logic                               mem_data_ok,
    output logic                               sel_return,
    output logic                               sel_way
);

    import icache_pkg::*;

    logic [state_width-1:0] state;
    logic [state_width-1:0] state_nxt;
    logic                   lookup;
    logic                   fetch_hit;
    logic                   need_mem;
    logic                   refill_done;

    //////////////////////////////////////////////////
    // lookup decode
    //////////////////////////////////////////////////

    assign lookup      = (state == st_lookup);
    assign fetch_hit   = lookup & ~buf_cacop & ~buf_uncached & (|hit);
    // uncached always goes out, even on a hit
    assign need_mem    = lookup & ~buf_cacop & (buf_uncached | (~|hit));
    assign refill_done = (state == st_miss_wait) & mem_data_ok;

    assign mem_req = need_mem | (state == st_miss_req);
    assign stall   = mem_req | (state == st_miss_wait);
    assign ready   = ~hold & ~stall;
    assign buf_we  = valid & ready;

    // refill into the victim way, uncached data is never kept
    assign data_we   = (refill_done & ~buf_uncached) ? (victim ? 2'b10 : 2'b01) : 2'b00;
    assign tag_we    = data_we;
    assign lru_touch = fetch_hit | (|data_we);
    assign lru_way   = fetch_hit ? hit[1] : victim;

    assign sel_return = (state == st_return);
    assign sel_way    = hit[1];

    // cache ops finish in the lookup cycle
    always_comb begin
        tag_inv  = 2'b00;
        tag_init = 1'b0;
        if (lookup && buf_cacop) begin
            case (buf_cacop_code)
                cacop_set_init: tag_init = 1'b1;
                cacop_idx_inv:  tag_inv[buf_way_bit] = 1'b1;
                cacop_hit_inv:  tag_inv = hit;
                default:        tag_inv = 2'b00;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (buf_we) begin
                    state_nxt = st_lookup;
                end
            end
            st_lookup: begin
                if (need_mem) begin
                    state_nxt = mem_addr_ok ? st_miss_wait : st_miss_req;
                end else if (!buf_we && !hold) begin
                    state_nxt = st_idle;
                end
            end
            st_miss_req: begin
                if (mem_addr_ok) begin
                    state_nxt = st_miss_wait;
                end
            end
            st_miss_wait: begin
                if (mem_data_ok) begin
                    state_nxt = st_return;
                end
            end
            st_return: begin
                if (buf_we) begin
                    state_nxt = st_lookup;
                end else if (!hold) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: verilog/icache_lru.sv
`timescale 1ns/1ps

module icache_lru (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [icache_pkg::index_width-1:0] index,
    input  logic                               hit_way,
    input  logic                               touch,
    output logic                               victim
);

    import icache_pkg::*;

    // one bit per set, names the least recently used way
    logic [set_count-1:0] lru_bits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (touch) begin
            // the way just used is safe, the other one goes next
            lru_bits[index] <= ~hit_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

// File: verilog/icache_pkg.sv
package icache_pkg;

    //////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////

    localparam int index_width  = 4;
    localparam int offset_width = 2;
    // everything above index and word offset, so the top index bits are kept too
    localparam int tag_width    = 32 - index_width - offset_width;
    localparam int line_words   = 1 << offset_width;
    localparam int set_count    = 1 << index_width;

    //////////////////////////////////////////////////
    // cache operations
    //////////////////////////////////////////////////

    localparam int cacop_width = 2;

    localparam logic [cacop_width-1:0] cacop_set_init = 2'd0;
    localparam logic [cacop_width-1:0] cacop_idx_inv  = 2'd1;
    localparam logic [cacop_width-1:0] cacop_hit_inv  = 2'd2;

    // controller states
    localparam int state_width = 3;

    localparam logic [state_width-1:0] st_idle      = 3'd0;
    localparam logic [state_width-1:0] st_lookup    = 3'd1;
    localparam logic [state_width-1:0] st_miss_req  = 3'd2;
    localparam logic [state_width-1:0] st_miss_wait = 3'd3;
    localparam logic [state_width-1:0] st_return    = 3'd4;

    // one line, seen as single words or as instruction pairs
    typedef union packed {
        logic [line_words-1:0][31:0]   word;
        logic [line_words/2-1:0][63:0] pair;
    } icache_line_u;

endpackage

// File: verilog/icache_rbuf.sv
`timescale 1ns/1ps

module icache_rbuf (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               we,
    input  logic                               hold,
    input  logic [31:0]                        addr,
    input  logic                               uncached,
    input  logic                               cacop,
    input  logic [icache_pkg::cacop_width-1:0] cacop_code,
    output logic [31:0]                        buf_addr,
    output logic                               buf_uncached,
    output logic                               buf_cacop,
    output logic [icache_pkg::cacop_width-1:0] buf_cacop_code
);

    logic capture;

    // frozen pipeline keeps the entry
    assign capture = we & ~hold;

    // request kind flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_cacop    <= 1'b0;
            buf_uncached <= 1'b0;
        end else if (capture) begin
            buf_cacop    <= cacop;
            buf_uncached <= uncached;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_addr       <= addr;
            buf_cacop_code <= cacop_code;
        end
    end

endmodule

// File: verilog/icache_tagv.sv
`timescale 1ns/1ps

module icache_tagv (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [icache_pkg::index_width-1:0] rd_index,
    input  logic [icache_pkg::tag_width-1:0]   cmp_tag,
    output logic [1:0]                         hit,
    input  logic [icache_pkg::index_width-1:0] wr_index,
    input  logic [icache_pkg::tag_width-1:0]   wr_tag,
    input  logic [1:0]                         wr_en,
    input  logic [1:0]                         inv_en,
    input  logic                               set_init
);

    import icache_pkg::*;

    logic [tag_width-1:0]      tag0_mem [set_count];
    logic [tag_width-1:0]      tag1_mem [set_count];
    logic [tag_width-1:0]      tag0_q;
    logic [tag_width-1:0]      tag1_q;
    logic [1:0][set_count-1:0] valid_bits;
    logic [1:0]                clr;
    logic [1:0]                valid_rd;
    logic [1:0]                valid_q;

    assign clr = inv_en | {2{set_init}};

    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            tag0_mem[wr_index] <= wr_tag;
        end
        if (wr_en[1]) begin
            tag1_mem[wr_index] <= wr_tag;
        end
        tag0_q <= tag0_mem[rd_index];
        tag1_q <= tag1_mem[rd_index];
    end

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (clr[w]) begin
                    valid_bits[w][wr_index] <= 1'b0;
                end else if (wr_en[w]) begin
                    valid_bits[w][wr_index] <= 1'b1;
                end
            end
        end
    end

    // forward an update to the same set, a fetch right after an invalidate must miss
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            valid_rd[w] = valid_bits[w][rd_index];
            if (rd_index == wr_index) begin
                valid_rd[w] = (valid_rd[w] | wr_en[w]) & ~clr[w];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 2'b00;
        end else begin
            valid_q <= valid_rd;
        end
    end

    assign hit[0] = valid_q[0] & (tag0_q == cmp_tag);
    assign hit[1] = valid_q[1] & (tag1_q == cmp_tag);

endmodule
